//--- vlog.f
+incdir+.
h2c_pkg.sv
h2c_pkt_fsm.sv
h2c_byte_counter.sv
h2c_ready_lfsr.sv
h2c_meta_check.sv
h2c_beat_check.sv
h2c_err_collect.sv
h2c_stream_check.sv
h2c_check_props.sv
tb_h2c_stream_check.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the H2C checker testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_h2c_stream_check -o sim_h2c
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi
./obj_dir/sim_h2c > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi
if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1

//--- h2c_tb_tasks.svh
/*
  Beat builder, bus driver and typed compare tasks for the H2C checker testbench
  Included inside the testbench module and works on its signals and beat queues
  Every beat repeats its metadata in both 64-bit halves
*/
////////////////////
// Beat queues, one entry per beat
h2c_pkg::data_t q_data[$];
h2c_pkg::par_t  q_pmask[$];  // XOR mask applied to the good parity
logic           q_last[$];
h2c_pkg::mty_t  q_mty[$];
h2c_pkg::qid_t  q_qid[$];
logic           q_err[$];

function automatic h2c_pkg::par_t odd_par(input h2c_pkg::data_t d);
  h2c_pkg::par_t p;
  for (int b = 0; b < 16; b++) p[b] = ~^d[8*b +: 8];  // Odd parity per byte
  return p;
endfunction

// Decoded metadata: btt 15..0, index 31..16, ctrl 00, qid 44..34, crc 63..56
function automatic logic [63:0] make_meta(input h2c_pkg::len_t btt, input h2c_pkg::len_t idx,
                                          input h2c_pkg::qid_t qid);
  logic [63:0] m;
  m = '0;
  m[15:0]  = btt;
  m[31:16] = idx;
  m[44:34] = qid;
  for (int c = 0; c < 8; c++) m[56+c] = ^m[7*c +: 7];
  return m;
endfunction

function automatic h2c_pkg::len_t pkt_len(input int nbeats, input h2c_pkg::mty_t mty);
  return h2c_pkg::len_t'(16 * nbeats) - h2c_pkg::len_t'(mty);  // Only last beat is partial
endfunction

task automatic push_packet(input int nbeats, input h2c_pkg::mty_t mty, input h2c_pkg::qid_t qid,
                           input logic invert, input h2c_pkg::len_t btt_adj);
  logic [63:0] meta;
  for (int k = 0; k < nbeats; k++) begin
    meta = make_meta(pkt_len(nbeats, mty) + btt_adj, h2c_pkg::len_t'(16 * k), qid);
    if (invert) meta = ~meta;  // Raw ctrl becomes 11
    q_data.push_back({meta, meta});
    q_pmask.push_back('0);
    q_last.push_back(k == nbeats - 1);
    q_mty.push_back((k == nbeats - 1) ? mty : h2c_pkg::mty_t'(0));
    q_qid.push_back(qid);
    q_err.push_back(1'b0);
  end
endtask

// Same flip in both halves keeps the pattern intact
task automatic flip_meta_bit(input int beat, input int bit_pos);
  q_data[beat][bit_pos]      = ~q_data[beat][bit_pos];
  q_data[beat][64 + bit_pos] = ~q_data[beat][64 + bit_pos];
endtask

task automatic compare_stat(input h2c_pkg::stat_word_t got, input h2c_pkg::stat_word_t exp,
                            input string what);
  if (got !== exp) begin
    $display("error %0t: %s status 0x%08h, expected 0x%08h", $time, what, got, exp);
    err_cnt++;
  end
endtask

task automatic compare_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
    err_cnt++;
  end
endtask

task automatic compare_len(input h2c_pkg::len_t got, input h2c_pkg::len_t exp, input string what);
  if (got !== exp) begin
    $display("error %0t: %s length %0d, expected %0d", $time, what, got, exp);
    err_cnt++;
  end
endtask

//--- tb_h2c_stream_check.sv
/*
  Directed testbench for the H2C stream checker
  Inputs change on the falling edge and ready is read there too since it is registered
  The run stops at a cycle limit sized from the beat count of all tests
*/
`timescale 1ns/1ps

module tb_h2c_stream_check;
  import h2c_pkg::*;

  localparam int TOTAL_BEATS = 39;                    // Beats over all tests
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

  logic       user_clk;
  logic       user_reset_n;
  data_t      h2c_tdata_i;
  par_t       h2c_dpar_i;
  logic       h2c_tlast_i;
  logic       h2c_tvalid_i;
  logic       h2c_tready_o;
  qid_t       h2c_tuser_qid_i;
  logic       h2c_tuser_err_i;
  mty_t       h2c_tuser_mty_i;
  logic       back_pres_i;
  logic       stat_vld_o;
  stat_word_t stat_err_o;

  int          err_cnt   = 0;
  int          test_cnt  = 0;
  int          cycles    = 0;
  int unsigned lcg_state = 69192;
  qid_t        pair_qid;   // Shared by the plain and back-pressure runs
  mty_t        pair_mty;

  `include "h2c_tb_tasks.svh"

  h2c_stream_check dut0 (.*);

  always #5 user_clk = ~user_clk;

  // Run limit
  always @(posedge user_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////
  // Drive queued beats and hold each until ready takes it
  task automatic send_packet();
    int i;
    i = 0;
    while (i < q_data.size()) begin
      @(negedge user_clk);
      h2c_tvalid_i    = 1'b1;
      h2c_tdata_i     = q_data[i];
      h2c_dpar_i      = odd_par(q_data[i]) ^ q_pmask[i];
      h2c_tlast_i     = q_last[i];
      h2c_tuser_mty_i = q_mty[i];
      h2c_tuser_qid_i = q_qid[i];
      h2c_tuser_err_i = q_err[i];
      if (h2c_tready_o) i++;  // Taken on the coming rising edge
    end
    @(negedge user_clk);
    h2c_tvalid_i    = 1'b0;
    h2c_tlast_i     = 1'b0;
    h2c_tuser_err_i = 1'b0;
    q_data.delete();
    q_pmask.delete();
    q_last.delete();
    q_mty.delete();
    q_qid.delete();
    q_err.delete();
  endtask

  // Send, wait for the strobe, check flags and length
  task automatic run_packet(input string what, input err_flags_t exp_f, input len_t exp_len);
    stat_word_t exp;
    int         n;
    send_packet();
    n = 0;
    while (!stat_vld_o && n < 20) begin
      @(negedge user_clk);
      n++;
    end
    if (!stat_vld_o) begin
      $display("%s: status strobe never came after the last beat", what);
      err_cnt++;
    end else begin
      exp                      = '0;
      exp[ST_QID]              = exp_f.qid;
      exp[ST_LEN]              = exp_f.len;
      exp[ST_PAR]              = exp_f.par;
      exp[ST_CRC]              = exp_f.crc;
      exp[ST_PCIE]             = exp_f.pcie;
      exp[ST_PAT]              = exp_f.pat;
      exp[ST_LEN_LSB +: LEN_W] = exp_len;
      compare_stat(stat_err_o, exp, what);
      compare_len(stat_err_o[ST_LEN_LSB +: LEN_W], exp_len, what);
      @(negedge user_clk);
      compare_flag(stat_vld_o, 1'b0, {what, " strobe one cycle later"});
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  // Good single-beat and multi-beat packets on the shared queue ID and empty count
  task automatic pair_packets(input string name);
    push_packet(1, '0, pair_qid, 1'b0, '0);
    run_packet({name, " single"}, '0, 16'd16);
    push_packet(4, pair_mty, pair_qid + qid_t'(1), 1'b0, '0);
    run_packet({name, " multi"}, '0, pkt_len(4, pair_mty));
  endtask

  ////////////////////
  // Tests
  task automatic good_pair();
    int e;
    e = err_cnt;
    pair_packets("good");
    finish_test("good", e);
  endtask

  task automatic inverted_meta();
    int e;
    e = err_cnt;
    push_packet(3, mty_t'(lcg_next() % 8), qid_t'(lcg_next()), 1'b1, '0);
    run_packet("inverted", '0, pkt_len(3, q_mty[2]));
    finish_test("inverted", e);
  endtask

  task automatic fault_run(input int kind, input string name);
    err_flags_t f;
    int         e;
    e = err_cnt;
    f = '0;
    push_packet(3, '0, qid_t'(lcg_next()), 1'b0, (kind == 5) ? len_t'(16) : len_t'(0));
    case (kind)
      0: begin
        flip_meta_bit(1, 57);  // CRC bit 1 of the middle beat
        f.crc = 1'b1;
      end
      1: begin
        q_qid[1] = q_qid[1] ^ qid_t'(1);
        f.qid = 1'b1;
      end
      2: begin
        q_pmask[2] = par_t'(16'h0100);
        f.par = 1'b1;
      end
      3: begin
        q_err[1] = 1'b1;
        f.pcie = 1'b1;
      end
      4: begin
        q_data[1][64 + 45] = 1'b1;  // Filler bit is zero below
        f.pat = 1'b1;
      end
      default: f.len = 1'b1;        // btt off by 16
    endcase
    run_packet(name, f, 16'd48);
    finish_test(name, e);
  endtask

  task automatic short_last();
    int e;
    e = err_cnt;
    push_packet(2, mty_t'(10), qid_t'(lcg_next()), 1'b0, '0);  // Six bytes in last beat
    flip_meta_bit(1, 60);
    run_packet("short last", '0, 16'd22);
    finish_test("short last", e);
  endtask

  task automatic back_pressure();
    int   n;
    logic seen_low;
    int   e;
    e = err_cnt;
    seen_low = 1'b0;
    back_pres_i = 1'b1;
    for (n = 0; n < 200 && !seen_low; n++) begin
      @(negedge user_clk);
      if (!h2c_tready_o) seen_low = 1'b1;
    end
    if (!seen_low) begin
      $display("back pressure: ready never dropped in 200 cycles");
      err_cnt++;
    end
    pair_packets("back pressure");
    back_pres_i = 1'b0;
    finish_test("back pressure", e);
  endtask

  task automatic sticky_reload();
    err_flags_t f;
    int         e;
    e = err_cnt;
    f = '0;
    f.crc = 1'b1;
    push_packet(3, '0, qid_t'(lcg_next()), 1'b0, '0);
    flip_meta_bit(0, 58);
    run_packet("reload bad", f, 16'd48);
    push_packet(3, '0, qid_t'(lcg_next()), 1'b0, '0);
    run_packet("reload good", '0, 16'd48);
    finish_test("sticky reload", e);
  endtask

  initial begin
    user_clk        = 1'b0;
    user_reset_n    = 1'b0;
    h2c_tdata_i     = '0;
    h2c_dpar_i      = '0;
    h2c_tlast_i     = 1'b0;
    h2c_tvalid_i    = 1'b0;
    h2c_tuser_qid_i = '0;
    h2c_tuser_err_i = 1'b0;
    h2c_tuser_mty_i = '0;
    back_pres_i     = 1'b0;
    pair_qid        = qid_t'(lcg_next());
    pair_mty        = mty_t'(lcg_next() % 8);
    repeat (5) @(posedge user_clk);
    @(negedge user_clk);
    user_reset_n = 1'b1;
    repeat (2) @(negedge user_clk);
    good_pair();
    inverted_meta();
    fault_run(0, "crc fault");
    fault_run(1, "qid fault");
    fault_run(2, "parity fault");
    fault_run(3, "pcie fault");
    fault_run(4, "pattern fault");
    fault_run(5, "length fault");
    short_last();
    back_pressure();
    sticky_reload();
    $display("summary: %0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- h2c_check_props.sv
/*
  Bus and strobe properties for the H2C checker, bound to the top level
*/
`timescale 1ns/1ps

module h2c_check_props (
  input logic user_clk,
  input logic user_reset_n,
  input logic h2c_tvalid_i,
  input logic h2c_tready_o,
  input logic h2c_tlast_i,
  input logic back_pres_i,
  input logic stat_vld_o
);

  // Strobe only follows an accepted last beat
  a_strobe: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    stat_vld_o |-> $past(h2c_tvalid_i && h2c_tready_o && h2c_tlast_i))
    else $error("status strobe without an accepted last beat");

  a_rst_ready: assert property (@(posedge user_clk) !user_reset_n |=> !h2c_tready_o)
    else $error("ready high during reset");

  // No back-pressure means ready on every following cycle
  a_no_bp: assert property (@(posedge user_clk) disable iff (!user_reset_n)
    !back_pres_i |=> h2c_tready_o)
    else $error("ready dropped without back-pressure");

endmodule

bind h2c_stream_check h2c_check_props u_props (.*);

//--- h2c_stream_check.sv
/*
  Receive-side checker for the H2C DMA packet stream
  Ready is driven here, with optional random back-pressure
  stat_err_o is valid in the stat_vld_o cycle and holds until the next packet starts
*/
`timescale 1ns/1ps

module h2c_stream_check (
  input  logic                 user_clk,
  input  logic                 user_reset_n,
  input  h2c_pkg::data_t       h2c_tdata_i,
  input  h2c_pkg::par_t        h2c_dpar_i,
  input  logic                 h2c_tlast_i,
  input  logic                 h2c_tvalid_i,
  output logic                 h2c_tready_o,
  input  h2c_pkg::qid_t        h2c_tuser_qid_i,
  input  logic                 h2c_tuser_err_i,
  input  h2c_pkg::mty_t        h2c_tuser_mty_i,
  input  logic                 back_pres_i,
  output logic                 stat_vld_o,
  output h2c_pkg::stat_word_t  stat_err_o
);
  import h2c_pkg::*;

  logic       beat_acc;  // Beat accepted this cycle
  logic       sop;       // First accepted beat of a packet
  len_t       len_prev;  // Bytes before current beat
  len_t       len;       // Bytes so far, including last accepted beat
  logic       crc_err;
  logic       qid_err;
  logic       len_err;
  logic       par_err;
  logic       pat_err;
  err_flags_t beat_err;  // Per-beat results into the sticky flags

  assign beat_err.qid  = qid_err;
  assign beat_err.len  = len_err;
  assign beat_err.par  = par_err;
  assign beat_err.crc  = crc_err;
  assign beat_err.pcie = h2c_tuser_err_i; // PCIe error is not masked on short beats
  assign beat_err.pat  = pat_err;

  h2c_ready_lfsr u_ready (
    .user_clk, .user_reset_n,
    .back_pres_i (back_pres_i),
    .tready_o    (h2c_tready_o)
  );

  h2c_pkt_fsm u_fsm (
    .user_clk, .user_reset_n,
    .tvalid_i   (h2c_tvalid_i),
    .tready_i   (h2c_tready_o),
    .tlast_i    (h2c_tlast_i),
    .beat_acc_o (beat_acc),
    .sop_o      (sop),
    .stat_vld_o (stat_vld_o)
  );

  h2c_byte_counter u_cnt (
    .user_clk, .user_reset_n,
    .beat_acc_i (beat_acc), .sop_i (sop), .tlast_i (h2c_tlast_i), .mty_i (h2c_tuser_mty_i),
    .len_prev_o (len_prev), .len_o (len)
  );

  h2c_meta_check u_meta (
    .tdata_i (h2c_tdata_i), .qid_i (h2c_tuser_qid_i), .mty_i (h2c_tuser_mty_i),
    .tlast_i (h2c_tlast_i), .sop_i (sop), .len_prev_i (len_prev),
    .crc_err_o (crc_err), .qid_err_o (qid_err), .len_err_o (len_err)
  );

  h2c_beat_check u_beat (
    .tdata_i (h2c_tdata_i), .dpar_i (h2c_dpar_i), .mty_i (h2c_tuser_mty_i),
    .tlast_i (h2c_tlast_i), .par_err_o (par_err), .pat_err_o (pat_err)
  );

  h2c_err_collect u_err (
    .user_clk, .user_reset_n,
    .beat_acc_i (beat_acc), .sop_i (sop), .beat_err_i (beat_err), .len_i (len),
    .stat_err_o (stat_err_o)
  );

endmodule

//--- h2c_err_collect.sv
/*
  Sticky per-packet error flags and status word
  Flags reload on the first beat of a packet and accumulate until its last beat
  The status word holds between packets and is meant to be sampled with the strobe
*/
`timescale 1ns/1ps

module h2c_err_collect (
  input  logic                user_clk,
  input  logic                user_reset_n,
  input  logic                beat_acc_i,
  input  logic                sop_i,
  input  h2c_pkg::err_flags_t beat_err_i,  // This beat's check results
  input  h2c_pkg::len_t       len_i,       // Bytes received so far
  output h2c_pkg::stat_word_t stat_err_o
);
  import h2c_pkg::*;

  err_flags_t flags_q;  // Sticky flags for the current packet

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      flags_q <= '0;
    end else if (beat_acc_i) begin
      if (sop_i) begin
        flags_q <= beat_err_i;            // Fresh packet
      end else begin
        flags_q <= flags_q | beat_err_i;  // Hold any earlier error
      end
    end
  end

  ////////////////////
  // Status word
  always_comb begin
    stat_err_o                       = '0;  // Reserved bits stay clear
    stat_err_o[ST_QID]               = flags_q.qid;
    stat_err_o[ST_LEN]               = flags_q.len;
    stat_err_o[ST_PAR]               = flags_q.par;
    stat_err_o[ST_CRC]               = flags_q.crc;
    stat_err_o[ST_PCIE]              = flags_q.pcie;
    stat_err_o[ST_PAT]               = flags_q.pat;
    stat_err_o[ST_LEN_LSB +: LEN_W]  = len_i;  // Received length
  end

endmodule

//--- h2c_beat_check.sv
/*
  Per-beat byte parity and repeating-pattern checks
  Parity is odd per byte and is skipped on beats shorter than the metadata
  Empty bytes are filled from the matching lower-word byte before the pattern compare
*/
`timescale 1ns/1ps

module h2c_beat_check (
  input  h2c_pkg::data_t tdata_i,
  input  h2c_pkg::par_t  dpar_i,   // Received parity, one bit per byte
  input  h2c_pkg::mty_t  mty_i,
  input  logic           tlast_i,
  output logic           par_err_o,
  output logic           pat_err_o
);
  import h2c_pkg::*;

  par_t             exp_par;   // Parity computed from data
  data_t            filled;    // Data with empty bytes patched
  logic [HDR_W-1:0] word_or;   // OR of all 64-bit words
  len_t             vbytes;
  logic             short_beat;

  assign vbytes     = valid_bytes(mty_i, tlast_i);
  assign short_beat = vbytes < len_t'(HDR_BYTES);

  ////////////////////
  // Per-byte parity and fill
  for (genvar b = 0; b < BYTES_W; b++) begin : g_byte
    assign exp_par[b] = ~^tdata_i[8*b +: 8];
  end

  assign filled[HDR_W-1:0] = tdata_i[HDR_W-1:0];  // An empty lower byte fills from itself
  for (genvar b = HDR_BYTES; b < BYTES_W; b++) begin : g_fill
    assign filled[8*b +: 8] = (len_t'(b) < vbytes) ? tdata_i[8*b +: 8]
                                                   : tdata_i[8*(b % HDR_BYTES) +: 8];
  end

  assign par_err_o = !short_beat && (dpar_i != exp_par);

  // Every word must repeat the lower one, so the OR of all words equals it
  always_comb begin
    word_or = filled[HDR_W-1:0];
    for (int w = 1; w < HDR_WORDS; w++) begin
      word_or = word_or | filled[w*HDR_W +: HDR_W];
    end
  end

  assign pat_err_o = (word_or != filled[HDR_W-1:0]);

endmodule

//--- h2c_meta_check.sv
/*
  Per-beat metadata decode with CRC, queue ID and length checks
  Metadata is the low 64 bits of the beat, inverted as a whole when the control field is set
  Beats with fewer than 8 valid bytes carry no usable metadata and raise no error here
  The length check covers one descriptor of BYTE_CREDIT bytes only
*/
`timescale 1ns/1ps

module h2c_meta_check (
  input  h2c_pkg::data_t tdata_i,
  input  h2c_pkg::qid_t  qid_i,       // Queue ID from tuser
  input  h2c_pkg::mty_t  mty_i,
  input  logic           tlast_i,
  input  logic           sop_i,
  input  h2c_pkg::len_t  len_prev_i,  // Bytes before this beat
  output logic           crc_err_o,
  output logic           qid_err_o,
  output logic           len_err_o
);
  import h2c_pkg::*;

  logic [HDR_W-1:0] meta_raw;  // Metadata as received
  logic [HDR_W-1:0] meta;      // After de-inversion
  logic [CRC_W-1:0] exp_crc;   // CRC computed from metadata
  len_t             btt;       // Bytes to transfer
  len_t             byte_idx;  // Byte index of this beat
  len_t             vbytes;    // Valid bytes in this beat
  logic             short_beat;
  logic             len_bad;   // Length rule before short-beat masking

  assign meta_raw = tdata_i[HDR_W-1:0];
  assign meta     = (meta_raw[CTRL_LSB +: CTRL_W] != '0) ? ~meta_raw : meta_raw;
  assign btt      = meta[BTT_LSB +: LEN_W];
  assign byte_idx = meta[IDX_LSB +: LEN_W];

  // Each CRC bit folds seven metadata bits
  for (genvar c = 0; c < CRC_W; c++) begin : g_crc
    assign exp_crc[c] = ^meta[c*CRC_SPAN +: CRC_SPAN];
  end

  assign vbytes     = valid_bytes(mty_i, tlast_i);
  assign short_beat = vbytes < len_t'(HDR_BYTES);  // Metadata cut short

  ////////////////////
  // Length bookkeeping
  always_comb begin
    if (sop_i && tlast_i) begin
      len_bad = (btt != vbytes);                    // Single-beat packet
    end else if (sop_i) begin
      len_bad = 1'b0;                               // First of several beats
    end else if (tlast_i) begin
      len_bad = (vbytes != (btt - byte_idx));       // Remainder must match
    end else begin
      len_bad = (len_t'(len_prev_i % BYTE_CREDIT) != len_t'(byte_idx % BYTE_CREDIT));
    end
  end

  assign crc_err_o = !short_beat && (meta[CRC_LSB +: CRC_W] != exp_crc);
  assign qid_err_o = !short_beat && (meta[QID_LSB +: QID_W] != qid_i);
  assign len_err_o = !short_beat && len_bad;

endmodule

//--- h2c_ready_lfsr.sv
/*
  Ready generator with optional random back-pressure
  Ready is registered and low in reset
  With back-pressure on, ready drops for a cycle whenever the LFSR tap bit is set
*/
`timescale 1ns/1ps

module h2c_ready_lfsr (
  input  logic user_clk,
  input  logic user_reset_n,
  input  logic back_pres_i,  // Enables random ready drops
  output logic tready_o
);
  import h2c_pkg::*;

  logic [31:0] lfsr_q;
  logic [31:0] lfsr_d;

  ////////////////////
  // Shift with taps
  always_comb begin
    lfsr_d[0] = lfsr_q[31];              // Wrap around
    lfsr_d[1] = lfsr_q[0] ^ lfsr_q[31];  // Feedback tap
    for (int i = 2; i <= 6; i++) begin
      lfsr_d[i] = lfsr_q[i-1] ^ lfsr_q[0];
    end
    for (int i = 7; i <= 15; i++) begin
      lfsr_d[i] = lfsr_q[i-1];           // Plain shift
    end
    for (int i = 16; i <= 23; i++) begin
      lfsr_d[i] = lfsr_q[i-1] ^ lfsr_q[1];
    end
    lfsr_d[24] = lfsr_q[23];
    lfsr_d[25] = lfsr_q[24];
    for (int i = 26; i <= 31; i++) begin
      lfsr_d[i] = ~lfsr_q[i-1];          // Inverting stages keep it from locking at zero
    end
  end

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      lfsr_q   <= LFSR_SEED;
      tready_o <= 1'b0;
    end else begin
      lfsr_q   <= lfsr_d;
      tready_o <= !(back_pres_i && lfsr_q[READY_TAP]);  // High every cycle without back-pressure
    end
  end

endmodule

//--- h2c_byte_counter.sv
/*
  Byte count of the current packet
  Only the last beat may be partial, so earlier beats always add 16 bytes
*/
`timescale 1ns/1ps

module h2c_byte_counter (
  input  logic          user_clk,
  input  logic          user_reset_n,
  input  logic          beat_acc_i,
  input  logic          sop_i,
  input  logic          tlast_i,
  input  h2c_pkg::mty_t mty_i,
  output h2c_pkg::len_t len_prev_o,  // Count before this beat
  output h2c_pkg::len_t len_o        // Count through last accepted beat
);
  import h2c_pkg::*;

  len_t len_q;
  len_t beat_bytes;  // Valid bytes in the current beat

  assign beat_bytes = valid_bytes(mty_i, tlast_i);
  assign len_prev_o = sop_i ? '0 : len_q;  // New packet has nothing before it
  assign len_o      = len_q;

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      len_q <= '0;
    end else if (beat_acc_i) begin
      len_q <= len_prev_o + beat_bytes;  // Restarts on sop, accumulates otherwise
    end
  end

endmodule

//--- h2c_pkt_fsm.sv
/*
  Packet boundary tracking on the valid/ready/last bus
  A single-beat packet is both start and end and leaves the FSM in IDLE
  stat_vld_o pulses one cycle after the edge that accepts a last beat
*/
`timescale 1ns/1ps

module h2c_pkt_fsm (
  input  logic user_clk,
  input  logic user_reset_n,
  input  logic tvalid_i,
  input  logic tready_i,
  input  logic tlast_i,
  output logic beat_acc_o,  // Valid and ready both high
  output logic sop_o,       // Accepted beat while idle
  output logic stat_vld_o   // Status strobe
);

  typedef enum logic {
    IDLE,  // Waiting for first beat
    BUSY   // Between first and last beat
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   eop;  // Accepted last beat

  assign beat_acc_o = tvalid_i & tready_i;
  assign sop_o      = beat_acc_o & (state_q == IDLE);
  assign eop        = beat_acc_o & tlast_i;

  ////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (sop_o && !tlast_i) state_d = BUSY; // Multi-beat packet opens
      end
      BUSY: begin
        if (eop) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (!user_reset_n) begin
      state_q    <= IDLE;
      stat_vld_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      stat_vld_o <= eop;  // One cycle, right after the last beat
    end
  end

endmodule

//--- h2c_pkg.sv
/*
  Shared widths, metadata field positions, status layout and types for the H2C checker
  Data width is fixed at 128 bits, so every beat holds two 64-bit metadata copies
  BYTE_CREDIT must be a power of two for the modulo length compare
*/
package h2c_pkg;

  ////////////////////
  // Bus and metadata sizes
  localparam int DATA_W      = 128;           // Bus data width
  localparam int BYTES_W     = DATA_W / 8;    // Bytes per beat
  localparam int MTY_W       = 4;             // Empty-byte count width
  localparam int HDR_W       = 64;            // Metadata word width
  localparam int HDR_BYTES   = HDR_W / 8;     // Metadata size in bytes
  localparam int HDR_WORDS   = DATA_W / HDR_W; // Metadata copies per beat
  localparam int QID_W       = 11;
  localparam int LEN_W       = 16;
  localparam int BYTE_CREDIT = 4096;          // Descriptor size for modulo compare

  localparam logic [31:0] LFSR_SEED = 32'h1ace_b00c; // Back-pressure generator start value
  localparam int          READY_TAP = 8;             // LFSR bit that drops ready

  // Metadata field positions, after de-inversion
  localparam int BTT_LSB  = 0;   // Bytes to transfer
  localparam int IDX_LSB  = 16;  // Byte index
  localparam int CTRL_LSB = 32;  // Inversion control
  localparam int CTRL_W   = 2;
  localparam int QID_LSB  = 34;
  localparam int CRC_LSB  = 56;
  localparam int CRC_W    = 8;
  localparam int CRC_SPAN = 7;   // Metadata bits folded into one CRC bit

  ////////////////////
  // Status word bit positions
  localparam int STAT_W     = 32;
  localparam int ST_QID     = 0;
  localparam int ST_LEN     = 1;
  localparam int ST_PAR     = 2;
  localparam int ST_CRC     = 3;
  localparam int ST_PCIE    = 4;
  localparam int ST_PAT     = 5;
  localparam int ST_LEN_LSB = 16; // Received length in bits 31..16

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [BYTES_W-1:0] par_t;
  typedef logic [MTY_W-1:0]   mty_t;
  typedef logic [QID_W-1:0]   qid_t;
  typedef logic [LEN_W-1:0]   len_t;
  typedef logic [STAT_W-1:0]  stat_word_t;

  typedef struct packed {
    logic qid;
    logic len;
    logic par;
    logic crc;
    logic pcie;
    logic pat;
  } err_flags_t;

  // Valid bytes of a beat; the empty count only counts on the last beat
  function automatic len_t valid_bytes(input mty_t mty, input logic last);
    return last ? (len_t'(BYTES_W) - len_t'(mty)) : len_t'(BYTES_W);
  endfunction

endpackage
